// ==== Bender.yml ====
package:
  name: cpu_control

sources:
  - include_dirs:
      - logic
    files:
      - logic/cpuControlPkg.sv
      - logic/interruptSync.sv
      - logic/flagUnit.sv
      - logic/phaseSequencer.sv
      - logic/controlDecoder.sv
      - logic/cpuControl.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verification/clockGen.sv
      - verification/cpuControlTb.sv

// ==== filelist.f ====
+incdir+logic
logic/cpuControlPkg.sv
logic/interruptSync.sv
logic/flagUnit.sv
logic/phaseSequencer.sv
logic/controlDecoder.sv
logic/cpuControl.sv
verification/clockGen.sv
verification/cpuControlTb.sv

// ==== logic/controlDecoder.sv ====
// Decode of phase and opcode into datapath, memory bus and status strobes
`timescale 1ns/1ps

module controlDecoder import cpuControlPkg::*; (
	input phase_t phase,
	input opcode_t opcode,
	input branch_t branchCode,
	input logic branchTaken,
	output datapathCtrl_t datapath,
	output memBusCtrl_t memBus,
	output logic statusWe,
	output logic intEnable,
	output logic intDisable,
	output logic multiCycle,
	output logic singleCycle
);

	// Instruction length, sampled by the sequencer in execute cycle 4
	always_comb begin
		multiCycle = 1'b0;
		singleCycle = 1'b0;
		case (opcode)
			LDW, STW: multiCycle = 1'b1;
			INTERRUPT: begin
				multiCycle = (branchCode == retiCode);
				singleCycle = (branchCode == eintCode) || (branchCode == dintCode);
			end
			ADD, ADDI, ADDIB, ADC, ADCI, SUB, SUBI, SUBIB, SUC, SUCI, NEG, CMP, CMPI,
			AND, OR, XOR, NOT, NAND, NOR, LSL, LSR, ASR, LUI, LLI, BRANCH:
				singleCycle = 1'b1;
			default: ;
		endcase
	end

	always_comb begin
		datapath = datapathIdle;
		memBus = memBusIdle;
		statusWe = 1'b0;
		intEnable = 1'b0;
		intDisable = 1'b0;
		case (phase.major)
			majorFetch:
				case (phase.sub)
					cycle0: begin
						memBus.ale = 1'b1; // PC out as address
						datapath.pcEn = 1'b1;
					end
					cycle1: begin
						memBus.nME = 1'b0;
						memBus.memEn = 1'b1;
						datapath.pcEn = 1'b1;
					end
					cycle2: begin
						memBus.nME = 1'b0;
						memBus.nOE = 1'b0;
						memBus.memEn = 1'b1;
						memBus.enb = 1'b1;
						datapath.irWe = 1'b1; // Reloads until nWait releases
					end
					cycle3: datapath.pcEn = 1'b1;
					default: ;
				endcase
			majorExecute:
				case (phase.sub)
					cycle4:
						case (opcode)
							ADD, ADDI, ADDIB, ADC, ADCI, SUB, SUBI, SUBIB, SUC, SUCI, NEG, CMP,
							CMPI, AND, OR, XOR, NOT, NAND, NOR, LSL, LSR, ASR, LUI, LLI: begin
								datapath.pcEn = 1'b1;
								datapath.pcWe = 1'b1; // PC + 1
								datapath.regWe = (opcode != CMP) && (opcode != CMPI);
								statusWe = 1'b1;
								case (opcode)
									ADD, ADC, SUB, SUC, CMP, AND, OR, XOR, NAND, NOR:
										datapath.op2Sel = op2Rd2;
									ADDI, ADCI, SUBI, SUCI, CMPI, LSL, LSR, ASR:
										datapath.immSel = immShort;
									ADDIB, SUBIB, LUI, LLI:
										datapath.rs1Sel = rs1Rd; // Rd is also the source
									default: ;
								endcase
							end
							LDW, STW: begin
								datapath.aluEn = 1'b1; // Effective address
								datapath.aluWe = 1'b1;
								datapath.immSel = immShort;
							end
							BRANCH: begin
								datapath.pcWe = 1'b1;
								datapath.aluEn = 1'b1;
								if (branchCode == JMP)
									datapath.immSel = immShort; // Register plus offset
								else
									datapath.op1Sel = op1Pc; // PC relative
								if (branchTaken)
									datapath.pcSel = pcAluOut;
							end
							INTERRUPT:
								case (branchCode)
									retiCode: begin
										datapath.rs1Sel = rs1Seven; // Stack pointer
										datapath.op2Sel = op2Zero;
										datapath.aluEn = 1'b1;
										datapath.aluWe = 1'b1;
									end
									eintCode, dintCode: begin
										datapath.pcEn = 1'b1;
										datapath.pcWe = 1'b1;
										intEnable = (branchCode == eintCode);
										intDisable = (branchCode == dintCode);
									end
									default: ;
								endcase
							default: ;
						endcase
					cycle0: begin
						memBus.ale = 1'b1; // Address from ALU register
						datapath.aluEn = 1'b1;
						if (opcode == INTERRUPT) begin
							datapath.rs1Sel = rs1Seven;
							datapath.op2Sel = op2Zero;
						end else begin
							datapath.immSel = immShort;
						end
					end
					cycle1: begin
						memBus.nME = 1'b0;
						datapath.aluEn = 1'b1;
						datapath.op2Sel = op2Zero;
						if (opcode == INTERRUPT) begin
							datapath.rs1Sel = rs1Seven;
						end else begin
							datapath.rs1Sel = rs1Rd; // Store data through the ALU
							datapath.aluWe = 1'b1;
							memBus.memEn = (opcode == LDW);
						end
					end
					cycle2: begin
						memBus.nME = 1'b0;
						if (opcode == STW) begin
							datapath.aluEn = 1'b1; // Data held on SysBus
							datapath.op2Sel = op2Zero;
						end else begin
							memBus.nOE = 1'b0;
							memBus.memEn = 1'b1;
							memBus.enb = 1'b1;
						end
						if (opcode == LDW) begin
							datapath.wdSel = wdSys;
							datapath.regWe = 1'b1;
						end
					end
					cycle3: begin
						datapath.pcWe = 1'b1; // PC advances once, after any stall
						if (opcode == STW) begin
							memBus.nWE = 1'b0;
							datapath.aluEn = 1'b1;
							datapath.op2Sel = op2Zero;
						end else if (opcode == INTERRUPT) begin
							datapath.pcSel = pcSysbus; // Return address from stack
							datapath.rs1Sel = rs1Seven;
							datapath.op2Sel = op2Zero;
							datapath.aluOr = aluOrAdd; // Pop
							datapath.rwSel = rwSeven;
							datapath.regWe = 1'b1;
							memBus.memEn = 1'b1;
						end else begin
							datapath.pcEn = 1'b1;
						end
					end
					default: ;
				endcase
			majorInterrupt:
				case (phase.sub)
					cycle4: begin
						intDisable = 1'b1; // No nesting
						datapath.rs1Sel = rs1Seven;
						datapath.op2Sel = op2Zero;
						datapath.aluOr = aluOrSub; // Push
						datapath.aluEn = 1'b1;
						datapath.aluWe = 1'b1;
						datapath.rwSel = rwSeven;
						datapath.regWe = 1'b1;
					end
					cycle0: begin
						memBus.ale = 1'b1;
						datapath.rs1Sel = rs1Seven;
						datapath.op2Sel = op2Zero;
						datapath.aluOr = aluOrSub;
						datapath.aluEn = 1'b1;
					end
					cycle1: begin
						memBus.nME = 1'b0;
						datapath.op2Sel = op2Zero;
						datapath.aluEn = 1'b1;
					end
					cycle2: begin
						memBus.nME = 1'b0;
						datapath.pcEn = 1'b1; // PC onto SysBus
					end
					cycle3: begin
						memBus.nWE = 1'b0;
						datapath.pcEn = 1'b1;
						datapath.pcSel = pcInt; // Interrupt vector
						datapath.pcWe = 1'b1;
					end
					default: ;
				endcase
			default: ;
		endcase
	end

endmodule

// ==== logic/cpuControl.sv ====
// Control unit top level with sequencer, decoder, flags and interrupt sync
`timescale 1ns/1ps
`include "cpuControl_config.svh"

module cpuControl import cpuControlPkg::*; (
	input logic Clock,
	input logic nReset,
	input logic [`OPCODE_WIDTH+`BRANCH_WIDTH-1:0] opcodeCondIn,
	input logic [`STATUS_WIDTH-1:0] flags,
	input logic nIRQ,
	input logic nWait,
	output datapathCtrl_t datapath,
	output memBusCtrl_t memBus,
	output logic [`STATUS_WIDTH-1:0] statusReg,
	output logic cFlag
);

	opcode_t opcode;
	branch_t branchCode;
	phase_t phase;
	logic multiCycle;
	logic singleCycle;
	logic statusWe;
	logic intEnable;
	logic intDisable;
	logic intReq;
	logic branchTaken;

	// Opcode in the upper bits, condition code below
	assign opcode = opcode_t'(opcodeCondIn[`OPCODE_WIDTH+`BRANCH_WIDTH-1:`BRANCH_WIDTH]);
	assign branchCode = branch_t'(opcodeCondIn[`BRANCH_WIDTH-1:0]);

	interruptSync irqSync (.Clock, .nReset, .nIRQ, .intEnable, .intDisable, .intReq);

	flagUnit flags0 (.Clock, .nReset, .flags, .statusWe, .branchCode, .statusReg, .cFlag,
		.branchTaken);

	phaseSequencer sequencer (.Clock, .nReset, .nWait, .intReq, .multiCycle, .singleCycle,
		.phase);

	controlDecoder decoder (.phase, .opcode, .branchCode, .branchTaken, .datapath, .memBus,
		.statusWe, .intEnable, .intDisable, .multiCycle, .singleCycle);

endmodule

// ==== logic/cpuControlPkg.sv ====
// Opcode, select, phase and control word types with idle control words
`include "cpuControl_config.svh"

package cpuControlPkg;

	typedef enum logic [`OPCODE_WIDTH-1:0] {
		ADD = 5'd0, ADDI = 5'd1, ADDIB = 5'd2, ADC = 5'd3, ADCI = 5'd4,
		SUB = 5'd5, SUBI = 5'd6, SUBIB = 5'd7, SUC = 5'd8, SUCI = 5'd9,
		NEG = 5'd10, CMP = 5'd11, CMPI = 5'd12, AND = 5'd13, OR = 5'd14,
		XOR = 5'd15, NOT = 5'd16, NAND = 5'd17, NOR = 5'd18, LSL = 5'd19,
		LSR = 5'd20, ASR = 5'd21, LUI = 5'd22, LLI = 5'd23, LDW = 5'd24,
		STW = 5'd25, BRANCH = 5'd26, INTERRUPT = 5'd27
	} opcode_t;

	// Codes 5 and 6 unused
	typedef enum logic [`BRANCH_WIDTH-1:0] {
		BR = 3'd0, BNE = 3'd1, BE = 3'd2, BLT = 3'd3, BGE = 3'd4, JMP = 3'd7
	} branch_t;

	// Sub-codes of INTERRUPT share the branch field
	localparam branch_t retiCode = branch_t'(3'd0);
	localparam branch_t eintCode = branch_t'(3'd1);
	localparam branch_t dintCode = branch_t'(3'd2);

	typedef enum logic {op1Rd1, op1Pc} op1Sel_t;
	typedef enum logic [1:0] {op2Imm, op2Rd2, op2Zero} op2Sel_t;
	typedef enum logic {immShort, immLong} immSel_t;
	typedef enum logic [1:0] {rs1Ra, rs1Rd, rs1Seven} rs1Sel_t;
	typedef enum logic [1:0] {rwRd, rwRa, rwSeven} rwSel_t;
	typedef enum logic {wdAlu, wdSys} wdSel_t;
	typedef enum logic [1:0] {pcPc1, pcAluOut, pcSysbus, pcInt} pcSel_t;
	typedef enum logic [1:0] {aluOrNone, aluOrAdd, aluOrSub} aluOr_t; // ALU op override

	typedef enum logic [1:0] {majorFetch, majorExecute, majorInterrupt} majorState_t;
	typedef enum logic [2:0] {cycle0, cycle1, cycle2, cycle3, cycle4} subCycle_t;

	typedef struct packed {
		majorState_t major;
		subCycle_t sub;
	} phase_t;

	typedef struct packed {
		logic aluEn;
		logic aluWe;
		aluOr_t aluOr;
		op1Sel_t op1Sel;
		op2Sel_t op2Sel;
		immSel_t immSel;
		rs1Sel_t rs1Sel;
		rwSel_t rwSel;
		wdSel_t wdSel;
		logic regWe;
		logic pcEn;
		logic pcWe;
		pcSel_t pcSel;
		logic irWe;
	} datapathCtrl_t;

	typedef struct packed {
		logic ale;
		logic memEn;
		logic enb;
		logic nME;
		logic nOE;
		logic nWE;
	} memBusCtrl_t;

	localparam datapathCtrl_t datapathIdle = '{
		aluEn: 1'b0, aluWe: 1'b0, aluOr: aluOrNone, op1Sel: op1Rd1, op2Sel: op2Imm,
		immSel: immLong, rs1Sel: rs1Ra, rwSel: rwRd, wdSel: wdAlu, regWe: 1'b0,
		pcEn: 1'b0, pcWe: 1'b0, pcSel: pcPc1, irWe: 1'b0
	};

	// Bus idle, all strobes inactive
	localparam memBusCtrl_t memBusIdle = '{
		ale: 1'b0, memEn: 1'b0, enb: 1'b0, nME: 1'b1, nOE: 1'b1, nWE: 1'b1
	};

endpackage

// ==== logic/cpuControl_config.svh ====
// Instruction field widths and status flag bit positions
`ifndef CPU_CONTROL_CONFIG_SVH
`define CPU_CONTROL_CONFIG_SVH

// Fields of the 8-bit opcode/condition byte
`define OPCODE_WIDTH 5
`define BRANCH_WIDTH 3

// Status register
`define STATUS_WIDTH 4

`define FLAG_Z 0 // Zero
`define FLAG_C 1 // Carry
`define FLAG_V 2 // Overflow
`define FLAG_N 3 // Negative

`endif

// ==== logic/flagUnit.sv ====
// Status register and branch condition evaluation
`timescale 1ns/1ps
`include "cpuControl_config.svh"

module flagUnit import cpuControlPkg::*; (
	input logic Clock,
	input logic nReset,
	input logic [`STATUS_WIDTH-1:0] flags,
	input logic statusWe,
	input branch_t branchCode,
	output logic [`STATUS_WIDTH-1:0] statusReg,
	output logic cFlag,
	output logic branchTaken
);

	always_ff @(posedge Clock or negedge nReset) begin
		if (!nReset)
			statusReg <= '0;
		else if (statusWe)
			statusReg <= flags; // ALU flags
	end

	assign cFlag = statusReg[`FLAG_C]; // Carry into ADC/SUC

	always_comb begin
		case (branchCode)
			BR, JMP: branchTaken = 1'b1;
			BNE: branchTaken = ~statusReg[`FLAG_Z];
			BE: branchTaken = statusReg[`FLAG_Z];
			// Signed compare
			BLT: branchTaken = statusReg[`FLAG_N] ^ statusReg[`FLAG_V];
			BGE: branchTaken = ~(statusReg[`FLAG_N] ^ statusReg[`FLAG_V]);
			default: branchTaken = 1'b0;
		endcase
	end

endmodule

// ==== logic/interruptSync.sv ====
// Interrupt request synchroniser and interrupt-enable register
`timescale 1ns/1ps

module interruptSync (
	input logic Clock,
	input logic nReset,
	input logic nIRQ,
	input logic intEnable,
	input logic intDisable,
	output logic intReq
);

	logic irqMeta;
	logic irqSync;
	logic intEnabled;

	always_ff @(posedge Clock or negedge nReset) begin
		if (!nReset) begin
			irqMeta <= 1'b0;
			irqSync <= 1'b0;
			intEnabled <= 1'b0;
		end else begin
			irqMeta <= ~nIRQ; // Request is active low
			irqSync <= irqMeta;
			if (intDisable)
				intEnabled <= 1'b0; // Disable wins on entry
			else if (intEnable)
				intEnabled <= 1'b1;
		end
	end

	assign intReq = irqSync & intEnabled;

endmodule

// ==== logic/phaseSequencer.sv ====
// Fetch, execute and interrupt-entry phase state machine
`timescale 1ns/1ps

module phaseSequencer import cpuControlPkg::*; (
	input logic Clock,
	input logic nReset,
	input logic nWait,
	input logic intReq,
	input logic multiCycle,
	input logic singleCycle,
	output phase_t phase
);

	localparam phase_t fetchStart = '{major: majorFetch, sub: cycle0};
	localparam phase_t executeFirst = '{major: majorExecute, sub: cycle4};
	localparam phase_t executeBus = '{major: majorExecute, sub: cycle0};
	localparam phase_t interruptEntry = '{major: majorInterrupt, sub: cycle4};

	phase_t nextPhase;
	phase_t endOfInstr;

	// Decision point at the end of every instruction
	assign endOfInstr = intReq ? interruptEntry : fetchStart;

	always_comb begin
		nextPhase = phase;
		case (phase.sub)
			cycle0: nextPhase.sub = cycle1;
			cycle1: nextPhase.sub = cycle2;
			cycle2:
				if (nWait || phase.major == majorInterrupt)
					nextPhase.sub = cycle3; // Bus stall on fetch and execute
			cycle3:
				case (phase.major)
					majorFetch: nextPhase = executeFirst;
					majorExecute: nextPhase = endOfInstr;
					default: nextPhase = fetchStart;
				endcase
			cycle4:
				case (phase.major)
					majorExecute:
						if (multiCycle)
							nextPhase = executeBus;
						else if (singleCycle)
							nextPhase = endOfInstr;
						else
							nextPhase = fetchStart; // Undefined opcode refetches
					majorInterrupt: nextPhase.sub = cycle0;
					default: nextPhase = fetchStart;
				endcase
			default: nextPhase = fetchStart;
		endcase
	end

	always_ff @(posedge Clock or negedge nReset) begin
		if (!nReset)
			phase <= fetchStart;
		else
			phase <= nextPhase;
	end

endmodule

// ==== verification/clockGen.sv ====
// Testbench clock and reset generator
`timescale 1ns/1ps

module clockGen (
	output logic Clock,
	output logic nReset
);

	initial begin
		Clock = 1'b0;
		forever #2 Clock = ~Clock; // 4 ns period
	end

	// Reset held for four rising edges
	initial begin
		nReset = 1'b0;
		repeat (4) @(posedge Clock);
		#1 nReset = 1'b1;
	end

endmodule

// ==== verification/cpuControlTb.sv ====
// Testbench for the control unit with stimulus table, cycle model and branch sweep
`timescale 1ns/1ps
`include "cpuControl_config.svh"

module cpuControlTb import cpuControlPkg::*; ();

	localparam int stallLimit = 20;
	localparam int fetchLimit = 40; // Longest instruction is well below this
	localparam logic [3:0] randStall = 4'hF; // Stall count drawn at random

	typedef struct packed {
		opcode_t op;
		branch_t bc;
		logic [`STATUS_WIDTH-1:0] fl;
		logic nIrq;
		logic [3:0] stall;
		logic [`STATUS_WIDTH-1:0] expStatus;
		pcSel_t expPc; // At the decision cycle
	} stimEntry_t;

	logic Clock;
	logic nReset;
	logic [`OPCODE_WIDTH+`BRANCH_WIDTH-1:0] opcodeCondIn;
	logic [`STATUS_WIDTH-1:0] flags;
	logic nIRQ;
	logic nWait;
	datapathCtrl_t datapath;
	memBusCtrl_t memBus;
	logic [`STATUS_WIDTH-1:0] statusReg;
	logic cFlag;

	stimEntry_t stimTable [16];
	logic [3:0] statusSet [5] = '{4'h0, 4'h1, 4'h8, 4'h4, 4'hC};
	branch_t branchSet [6] = '{BR, BNE, BE, BLT, BGE, JMP};
	int errorCount = 0;
	int timeoutCount = 0;
	logic modelEnabled = 1'b0; // Interrupt-enable bit as the model sees it

	clockGen clocks (.Clock, .nReset);

	cpuControl uut (.Clock, .nReset, .opcodeCondIn, .flags, .nIRQ, .nWait, .datapath,
		.memBus, .statusReg, .cFlag);

	task automatic reportMismatch(input string msg);
		errorCount++;
		$display("CHECK FAILED at %0t: %s", $time, msg);
	endtask

	task automatic reportTimeout(input string what);
		timeoutCount++;
		$display("Timeout at %0t: %s", $time, what);
	endtask

	task automatic nextCycle();
		@(posedge Clock);
		#1;
	endtask

	function automatic logic branchRule(input branch_t bc, input logic [3:0] st);
		case (bc)
			BR, JMP: return 1'b1;
			BNE: return !st[`FLAG_Z];
			BE: return st[`FLAG_Z];
			BLT: return st[`FLAG_N] != st[`FLAG_V]; // Signed less than
			BGE: return st[`FLAG_N] == st[`FLAG_V];
			default: return 1'b0;
		endcase
	endfunction

	// Fetch cycle 0 is the only one with ale and pcEn together
	task automatic waitFetchStart(output logic ok);
		int guard;
		guard = 0;
		while (!(memBus.ale && datapath.pcEn) && guard < fetchLimit) begin
			nextCycle();
			guard++;
		end
		ok = memBus.ale && datapath.pcEn;
		if (!ok)
			reportTimeout("sequencer never returned to fetch cycle 0");
	endtask

	// Holds nWait low for the stall count and counts cycles spent in sub-cycle 2
	task automatic holdStall(input opcode_t op, input int stall, input logic inFetch,
		output int cycles);
		int left;
		left = stall;
		cycles = 0;
		while ((inFetch ? datapath.irWe : !datapath.pcWe) && cycles < stallLimit) begin
			if (memBus.nME)
				reportMismatch("nME high during bus cycle 2");
			if (!inFetch && !memBus.nWE)
				reportMismatch("nWE low before execute cycle 3");
			if (!inFetch && op == LDW && !(datapath.regWe && datapath.wdSel == wdSys))
				reportMismatch("LDW without register write from Sys in execute cycle 2");
			cycles++;
			nWait = (left == 0);
			if (left > 0)
				left--;
			nextCycle();
		end
		nWait = 1'b1;
		if (cycles >= stallLimit)
			reportTimeout("bus cycle 2 never ended after nWait released");
	endtask

	task automatic checkDecision(input stimEntry_t e);
		if (!datapath.pcWe || datapath.pcSel != e.expPc)
			reportMismatch($sformatf("opcode %0d code %0d: pcSel %0d pcWe %b, expected pcSel %0d",
				e.op, e.bc, datapath.pcSel, datapath.pcWe, e.expPc));
	endtask

	// One instruction from fetch cycle 0 back to fetch cycle 0
	task automatic runInstr(input stimEntry_t e);
		logic ok;
		logic multi;
		logic aluOp;
		logic takeInt;
		int stall;
		int cycles;
		waitFetchStart(ok);
		if (!ok)
			return;
		multi = (e.op == LDW) || (e.op == STW) || (e.op == INTERRUPT && e.bc == retiCode);
		aluOp = !multi && e.op != BRANCH && e.op != INTERRUPT;
		takeInt = modelEnabled && !e.nIrq;
		if (e.stall == randStall)
			stall = $urandom % 4;
		else
			stall = e.stall;
		if (!memBus.nME || datapath.regWe || memBus.memEn)
			reportMismatch("fetch cycle 0 strobes wrong");
		opcodeCondIn = {e.op, e.bc};
		flags = e.fl;
		nIRQ = e.nIrq;
		nextCycle();
		if (memBus.nME)
			reportMismatch("nME high in fetch cycle 1");
		nextCycle();
		holdStall(e.op, stall, 1'b1, cycles);
		if (cycles >= stallLimit)
			return;
		if (cycles != stall + 1)
			reportMismatch($sformatf("irWe high %0d cycles, expected %0d", cycles, stall + 1));
		nextCycle(); // Execute cycle 4
		if (datapath.regWe != (aluOp && e.op != CMP && e.op != CMPI))
			reportMismatch($sformatf("regWe %b wrong in execute cycle 4, opcode %0d",
				datapath.regWe, e.op));
		if (!multi)
			checkDecision(e);
		else begin
			nextCycle();
			if (!memBus.ale || !memBus.nWE)
				reportMismatch("execute cycle 0 address strobes wrong");
			nextCycle();
			if (memBus.nME || !memBus.nWE)
				reportMismatch("execute cycle 1 bus strobes wrong");
			nextCycle();
			holdStall(e.op, stall, 1'b0, cycles);
			if (cycles >= stallLimit)
				return;
			if (cycles != stall + 1)
				reportMismatch($sformatf("execute stall %0d cycles, expected %0d", cycles,
					stall + 1));
			if (memBus.nWE != (e.op != STW))
				reportMismatch("nWE wrong in execute cycle 3");
			checkDecision(e);
		end
		nextCycle();
		if (statusReg != e.expStatus)
			reportMismatch($sformatf("statusReg %h, expected %h", statusReg, e.expStatus));
		if (cFlag != e.expStatus[`FLAG_C])
			reportMismatch($sformatf("cFlag %b, expected %b", cFlag, e.expStatus[`FLAG_C]));
		if (takeInt) begin
			if (memBus.ale)
				reportMismatch("interrupt entry did not start");
			repeat (4) nextCycle(); // Interrupt cycles 0 to 3
			if (!datapath.pcWe || datapath.pcSel != pcInt || memBus.nWE)
				reportMismatch("interrupt cycle 3 does not load the vector");
			modelEnabled = 1'b0; // Entry disables nesting
			nextCycle();
		end
		if (!(memBus.ale && datapath.pcEn))
			reportMismatch("no return to fetch cycle 0 after the instruction");
		if (e.op == INTERRUPT && e.bc == eintCode)
			modelEnabled = 1'b1;
		else if (e.op == INTERRUPT && e.bc == dintCode)
			modelEnabled = 1'b0;
	endtask

	task automatic fillTable();
		stimTable[0] = '{ADD, BR, 4'h5, 1'b1, 4'd0, 4'h5, pcPc1};
		stimTable[1] = '{ADDI, BR, 4'h2, 1'b1, 4'd2, 4'h2, pcPc1};
		stimTable[2] = '{CMP, BR, 4'h1, 1'b1, 4'd1, 4'h1, pcPc1}; // Sets Z
		stimTable[3] = '{BRANCH, BE, 4'hF, 1'b1, 4'd0, 4'h1, pcAluOut};
		stimTable[4] = '{BRANCH, BNE, 4'h0, 1'b1, 4'd0, 4'h1, pcPc1};
		stimTable[5] = '{LDW, BR, 4'h8, 1'b1, randStall, 4'h1, pcPc1};
		stimTable[6] = '{STW, BR, 4'h0, 1'b1, 4'd2, 4'h1, pcPc1};
		stimTable[7] = '{LSL, BR, 4'hC, 1'b1, randStall, 4'hC, pcPc1};
		stimTable[8] = '{INTERRUPT, eintCode, 4'h0, 1'b0, 4'd0, 4'hC, pcPc1};
		stimTable[9] = '{SUB, BR, 4'h3, 1'b0, 4'd0, 4'h3, pcPc1}; // Interrupted
		stimTable[10] = '{INTERRUPT, retiCode, 4'h0, 1'b0, 4'd1, 4'h3, pcSysbus};
		stimTable[11] = '{INTERRUPT, eintCode, 4'h0, 1'b1, 4'd0, 4'h3, pcPc1};
		stimTable[12] = '{INTERRUPT, dintCode, 4'h0, 1'b1, 4'd0, 4'h3, pcPc1};
		stimTable[13] = '{OR, BR, 4'h6, 1'b0, 4'd0, 4'h6, pcPc1}; // Request ignored
		stimTable[14] = '{BRANCH, JMP, 4'h0, 1'b0, 4'd1, 4'h6, pcAluOut};
		stimTable[15] = '{LUI, BR, 4'h0, 1'b1, 4'd0, 4'h0, pcPc1};
	endtask

	initial begin
		int seed;
		int guard;
		stimEntry_t e;
		seed = 50;
		void'($urandom(seed));
		opcodeCondIn = {LUI, BR};
		flags = '0;
		nIRQ = 1'b1;
		nWait = 1'b1;
		fillTable();
		@(posedge Clock);
		#1;
		if (!memBus.ale || !memBus.nME || datapath.regWe || datapath.pcWe || datapath.irWe ||
			datapath.aluWe || memBus.memEn || statusReg != '0)
			reportMismatch("control outputs not idle during reset");
		guard = 0;
		while (!nReset && guard < fetchLimit) begin
			@(posedge Clock);
			guard++;
		end
		#1;
		if (!nReset)
			reportTimeout("reset never released");
		else begin
			for (int i = 0; i < 16 && timeoutCount == 0; i++)
				runInstr(stimTable[i]);
			// CMP preloads each status value before every branch code
			foreach (statusSet[s])
				foreach (branchSet[b])
					if (timeoutCount == 0) begin
						e = '{CMP, BR, statusSet[s], 1'b1, 4'd0, statusSet[s], pcPc1};
						runInstr(e);
						e = '{BRANCH, branchSet[b], 4'h0, 1'b1, 4'd1, statusSet[s], pcPc1};
						if (branchRule(branchSet[b], statusSet[s]))
							e.expPc = pcAluOut;
						runInstr(e);
					end
		end
		$display("Errors: %0d check failures, %0d timeouts", errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule
